/* verilog/simple_processor_pkg.sv */
////////////////////
// Machine sizes for the simple processor
// Bus widths, register count and PC step
////////////////////

package simple_processor_pkg;

  // Both address buses
  localparam int ADDR_WIDTH    = 16;
  // Data buses, registers and one instruction word
  localparam int DATA_WIDTH    = 16;

  // Register file geometry
  localparam int NUM_REGS      = 8;
  localparam int REG_IDX_WIDTH = 3;

  // Bytes per instruction, PC step
  localparam int INSTR_BYTES   = 2;

endpackage

/* verilog/simple_processor_isa_pkg.sv */
////////////////////
// Instruction set of the simple processor
// Opcodes, field positions and ALU operations
////////////////////

package simple_processor_isa_pkg;

  // Major opcodes, any other code is a no-op
  typedef enum logic [3:0] {
    OP_ADD   = 4'd0,
    OP_SUB   = 4'd1,
    OP_AND   = 4'd2,
    OP_OR    = 4'd3,
    OP_XOR   = 4'd4,
    OP_ADDI  = 4'd5,
    OP_LOAD  = 4'd6,
    OP_STORE = 4'd7,
    OP_BEQZ  = 4'd8,
    OP_HALT  = 4'd9
  } opcode_e;

  // ALU functions
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4
  } alu_op_e;

  // Field positions in the instruction word
  localparam int OPCODE_MSB = 15;
  localparam int OPCODE_LSB = 12;
  localparam int RD_MSB     = 11;
  localparam int RD_LSB     = 9;
  localparam int RS1_MSB    = 8;
  localparam int RS1_LSB    = 6;
  localparam int RS2_MSB    = 5;
  localparam int RS2_LSB    = 3;
  // Immediate overlaps rs2, two's complement
  localparam int IMM_MSB    = 5;
  localparam int IMM_LSB    = 0;
  localparam int IMM_WIDTH  = 6;

endpackage

/* verilog/ins_dec.sv */
////////////////////
// Instruction decoder
// Splits an instruction into fields and control
////////////////////

`timescale 1ns/100ps

module ins_dec
  import simple_processor_pkg::*;
  import simple_processor_isa_pkg::*;
(
  // Instruction word under execution
  input  logic [DATA_WIDTH-1:0]    instr_i,
  // Raw opcode field
  output opcode_e                  opcode_o,
  // Register indices
  output logic [REG_IDX_WIDTH-1:0] rd_o,
  output logic [REG_IDX_WIDTH-1:0] rs1_o,
  output logic [REG_IDX_WIDTH-1:0] rs2_o,
  // Sign-extended immediate
  output logic [DATA_WIDTH-1:0]    imm_o,
  // ALU control
  output alu_op_e                  alu_op_o,
  output logic                     alu_use_imm_o,
  // Writes rd
  output logic                     reg_we_o,
  // Load or store
  output logic                     mem_access_o
);

  ////////////////////
  // Field split
  ////////////////////

  assign opcode_o = opcode_e'(instr_i[OPCODE_MSB:OPCODE_LSB]);
  assign rd_o     = instr_i[RD_MSB:RD_LSB];
  assign rs1_o    = instr_i[RS1_MSB:RS1_LSB];
  assign rs2_o    = instr_i[RS2_MSB:RS2_LSB];

  // Replicate imm6 sign bit up to full width
  assign imm_o = {{(DATA_WIDTH-IMM_WIDTH){instr_i[IMM_MSB]}}, instr_i[IMM_MSB:IMM_LSB]};

  ////////////////////
  // Control
  ////////////////////

  always_comb begin
    // No-op unless an opcode matches
    alu_op_o      = ALU_ADD;
    alu_use_imm_o = 1'b0;
    reg_we_o      = 1'b0;
    mem_access_o  = 1'b0;
    case (opcode_o)
      OP_ADD: begin
        alu_op_o = ALU_ADD;
        reg_we_o = 1'b1;
      end
      OP_SUB: begin
        alu_op_o = ALU_SUB;
        reg_we_o = 1'b1;
      end
      OP_AND: begin
        alu_op_o = ALU_AND;
        reg_we_o = 1'b1;
      end
      OP_OR: begin
        alu_op_o = ALU_OR;
        reg_we_o = 1'b1;
      end
      OP_XOR: begin
        alu_op_o = ALU_XOR;
        reg_we_o = 1'b1;
      end
      OP_ADDI: begin
        alu_use_imm_o = 1'b1;
        reg_we_o      = 1'b1;
      end
      // Address is rs1 + imm for both memory ops
      OP_LOAD: begin
        alu_use_imm_o = 1'b1;
        reg_we_o      = 1'b1;
        mem_access_o  = 1'b1;
      end
      OP_STORE: begin
        alu_use_imm_o = 1'b1;
        mem_access_o  = 1'b1;
      end
      // rd OR r0 feeds the zero flag
      OP_BEQZ: alu_op_o = ALU_OR;
      default: alu_op_o = ALU_ADD;
    endcase
  end

endmodule

/* verilog/reg_file.sv */
////////////////////
// Register file, 2 read and 1 write port
// r0 is hardwired to zero
////////////////////

`timescale 1ns/100ps

module reg_file
  import simple_processor_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     arst_ni,
  // Read indices
  input  logic [REG_IDX_WIDTH-1:0] rs1_i,
  input  logic [REG_IDX_WIDTH-1:0] rs2_i,
  // Write port
  input  logic                     we_i,
  input  logic [REG_IDX_WIDTH-1:0] wa_i,
  input  logic [DATA_WIDTH-1:0]    wd_i,
  // Read data, same cycle
  output logic [DATA_WIDTH-1:0]    rd1_o,
  output logic [DATA_WIDTH-1:0]    rd2_o
);

  logic [DATA_WIDTH-1:0] regs_q [NUM_REGS];

  // Writes to r0 are dropped
  always_ff @(posedge clk_i or negedge arst_ni) begin
    if (!arst_ni) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (wa_i != '0)) begin
      regs_q[wa_i] <= wd_i;
    end
  end

  // Asynchronous reads, r0 forced to zero
  assign rd1_o = (rs1_i == '0) ? '0 : regs_q[rs1_i];
  assign rd2_o = (rs2_i == '0) ? '0 : regs_q[rs2_i];

endmodule

/* verilog/alu.sv */
////////////////////
// 16-bit ALU with zero flag
////////////////////

`timescale 1ns/100ps

module alu
  import simple_processor_pkg::*;
  import simple_processor_isa_pkg::*;
(
  // Operation select
  input  alu_op_e               op_i,
  // Operands
  input  logic [DATA_WIDTH-1:0] a_i,
  input  logic [DATA_WIDTH-1:0] b_i,
  // Result, wraps at full width
  output logic [DATA_WIDTH-1:0] result_o,
  // High when result is all zeros
  output logic                  zero_o
);

  always_comb begin
    case (op_i)
      ALU_ADD: result_o = a_i + b_i;
      ALU_SUB: result_o = a_i - b_i;
      ALU_AND: result_o = a_i & b_i;
      ALU_OR:  result_o = a_i | b_i;
      ALU_XOR: result_o = a_i ^ b_i;
      // Unused encodings
      default: result_o = '0;
    endcase
  end

  // Branch condition source
  assign zero_o = (result_o == '0);

endmodule

/* verilog/simple_processor.sv */
////////////////////
// Simple multicycle 16-bit load/store core
// Fetch, execute and memory states over
// req/ack instruction and data ports
////////////////////

`timescale 1ns/100ps

module simple_processor
  import simple_processor_pkg::*;
  import simple_processor_isa_pkg::*;
(
  input  logic                  clk_i,
  // Active low, asynchronous
  input  logic                  arst_ni,
  // First PC after reset
  input  logic [ADDR_WIDTH-1:0] boot_addr_i,

  // Instruction port
  output logic                  imem_req_o,
  output logic [ADDR_WIDTH-1:0] imem_addr_o,
  input  logic [DATA_WIDTH-1:0] imem_rdata_i,
  input  logic                  imem_ack_i,

  // Data port, word addressed
  output logic                  dmem_req_o,
  output logic                  dmem_we_o,
  output logic [ADDR_WIDTH-1:0] dmem_addr_o,
  output logic [DATA_WIDTH-1:0] dmem_wdata_o,
  input  logic [DATA_WIDTH-1:0] dmem_rdata_i,
  input  logic                  dmem_ack_i,

  // Stays high once HALT has executed
  output logic                  halted_o
);

  ////////////////////
  // Signals
  ////////////////////

  typedef enum logic [2:0] {
    RESET,
    FETCH,
    EXEC,
    MEM,
    HALT
  } state_e;

  state_e                   state_q;
  state_e                   state_d;

  // Program counter
  logic [ADDR_WIDTH-1:0]    pc_q;
  logic [ADDR_WIDTH-1:0]    pc_next;
  logic [ADDR_WIDTH-1:0]    pc_plus;
  logic [ADDR_WIDTH-1:0]    br_target;
  logic                     valid_pc;
  logic                     pc_en;

  // Latched instruction word
  logic [DATA_WIDTH-1:0]    instr_q;

  // Decoder outputs
  opcode_e                  dec_opcode;
  logic [REG_IDX_WIDTH-1:0] dec_rd;
  logic [REG_IDX_WIDTH-1:0] dec_rs1;
  logic [REG_IDX_WIDTH-1:0] dec_rs2;
  logic [DATA_WIDTH-1:0]    dec_imm;
  alu_op_e                  dec_alu_op;
  logic                     dec_use_imm;
  logic                     dec_reg_we;
  logic                     dec_mem;

  // Datapath
  logic [REG_IDX_WIDTH-1:0] rs1_sel;
  logic [REG_IDX_WIDTH-1:0] rs2_sel;
  logic [DATA_WIDTH-1:0]    rd1;
  logic [DATA_WIDTH-1:0]    rd2;
  logic [DATA_WIDTH-1:0]    alu_b;
  logic [DATA_WIDTH-1:0]    alu_result;
  logic                     alu_zero;
  logic                     rf_we;
  logic [DATA_WIDTH-1:0]    rf_wd;
  logic                     is_beqz;
  logic                     br_taken;

  // Data port payload
  logic [ADDR_WIDTH-1:0]    dmem_addr_q;
  logic [DATA_WIDTH-1:0]    dmem_wdata_q;
  logic                     dmem_we_q;

  ////////////////////
  // Submodules
  ////////////////////

  ins_dec u_ins_dec (
    .instr_i       (instr_q),
    .opcode_o      (dec_opcode),
    .rd_o          (dec_rd),
    .rs1_o         (dec_rs1),
    .rs2_o         (dec_rs2),
    .imm_o         (dec_imm),
    .alu_op_o      (dec_alu_op),
    .alu_use_imm_o (dec_use_imm),
    .reg_we_o      (dec_reg_we),
    .mem_access_o  (dec_mem)
  );

  reg_file u_reg_file (
    .clk_i   (clk_i),
    .arst_ni (arst_ni),
    .rs1_i   (rs1_sel),
    .rs2_i   (rs2_sel),
    .we_i    (rf_we),
    .wa_i    (dec_rd),
    .wd_i    (rf_wd),
    .rd1_o   (rd1),
    .rd2_o   (rd2)
  );

  alu u_alu (
    .op_i     (dec_alu_op),
    .a_i      (rd1),
    .b_i      (alu_b),
    .result_o (alu_result),
    .zero_o   (alu_zero)
  );

  ////////////////////
  // Datapath
  ////////////////////

  assign is_beqz = (dec_opcode == OP_BEQZ);

  // Branch tests rd | r0, so port 1 reads r0
  assign rs1_sel = is_beqz ? '0 : dec_rs1;
  // rd comes out on port 2 for store data and branch test
  assign rs2_sel = (is_beqz || (dec_opcode == OP_STORE)) ? dec_rd : dec_rs2;

  assign alu_b    = dec_use_imm ? dec_imm : rd2;
  assign br_taken = is_beqz && alu_zero;

  // Write-back in EXEC, or in MEM on the load ack
  assign rf_we = ((state_q == EXEC) && dec_reg_we && !dec_mem) ||
                 ((state_q == MEM) && dmem_ack_i && !dmem_we_q);
  assign rf_wd = (state_q == MEM) ? dmem_rdata_i : alu_result;

  ////////////////////
  // Program counter
  ////////////////////

  assign pc_plus = pc_q + ADDR_WIDTH'(INSTR_BYTES);
  // Offset counts instructions, so shift by one
  assign br_target = pc_plus + {dec_imm[ADDR_WIDTH-2:0], 1'b0};

  always_comb begin
    case (valid_pc)
      1'b1:    pc_next = br_taken ? br_target : pc_plus;
      default: pc_next = boot_addr_i;
    endcase
  end

  // Boot load, then once per retired instruction
  assign pc_en = (state_q == RESET) ||
                 ((state_q == EXEC) && !dec_mem && (dec_opcode != OP_HALT)) ||
                 ((state_q == MEM) && dmem_ack_i);

  always_ff @(posedge clk_i or negedge arst_ni) begin
    if (!arst_ni) begin
      pc_q     <= '0;
      valid_pc <= 1'b0;
    end else if (pc_en) begin
      pc_q     <= pc_next;
      valid_pc <= 1'b1;
    end
  end

  ////////////////////
  // Control FSM
  ////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      RESET: state_d = FETCH;
      FETCH: begin
        if (imem_ack_i) begin
          state_d = EXEC;
        end
      end
      EXEC: begin
        if (dec_opcode == OP_HALT) begin
          state_d = HALT;
        end else if (dec_mem) begin
          state_d = MEM;
        end else begin
          state_d = FETCH;
        end
      end
      MEM: begin
        if (dmem_ack_i) begin
          state_d = FETCH;
        end
      end
      // Only reset leaves HALT
      HALT:    state_d = HALT;
      default: state_d = RESET;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_ni) begin
    if (!arst_ni) begin
      state_q   <= RESET;
      dmem_we_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if ((state_q == EXEC) && dec_mem) begin
        dmem_we_q <= (dec_opcode == OP_STORE);
      end
    end
  end

  // Instruction captured in the ack cycle
  always_ff @(posedge clk_i) begin
    if ((state_q == FETCH) && imem_ack_i) begin
      instr_q <= imem_rdata_i;
    end
  end

  // Address and store data held through MEM
  always_ff @(posedge clk_i) begin
    if ((state_q == EXEC) && dec_mem) begin
      dmem_addr_q  <= alu_result[ADDR_WIDTH-1:0];
      dmem_wdata_q <= rd2;
    end
  end

  ////////////////////
  // Outputs
  ////////////////////

  assign imem_req_o   = (state_q == FETCH);
  assign imem_addr_o  = pc_q;
  assign dmem_req_o   = (state_q == MEM);
  assign dmem_we_o    = dmem_req_o && dmem_we_q;
  assign dmem_addr_o  = dmem_addr_q;
  assign dmem_wdata_o = dmem_wdata_q;
  assign halted_o     = (state_q == HALT);

endmodule

/* bench/tb_simple_processor.sv */
////////////////////
// Testbench for the simple processor
// Memory models with random ack delay, a reference
// model and directed program tests
////////////////////

`timescale 1ns/100ps

module tb_simple_processor
  import simple_processor_pkg::*;
  import simple_processor_isa_pkg::*;
();

  // 6 runs of at most ~20 instructions at <= 10 cycles, plus idle checks
  localparam int TIMEOUT_CYCLES = 2000;
  localparam int MEM_WORDS      = 256;

  logic                  clk;
  logic                  arst_n;
  logic [ADDR_WIDTH-1:0] boot_addr;
  logic                  imem_req;
  logic [ADDR_WIDTH-1:0] imem_addr;
  logic [DATA_WIDTH-1:0] imem_rdata;
  logic                  imem_ack;
  logic                  dmem_req;
  logic                  dmem_we;
  logic [ADDR_WIDTH-1:0] dmem_addr;
  logic [DATA_WIDTH-1:0] dmem_wdata;
  logic [DATA_WIDTH-1:0] dmem_rdata;
  logic                  dmem_ack;
  logic                  halted;

  // Memory models, reference copy and a snapshot for run comparison
  logic [DATA_WIDTH-1:0] imem [MEM_WORDS];
  logic [DATA_WIDTH-1:0] dmem [MEM_WORDS];
  logic [DATA_WIDTH-1:0] ref_dmem [MEM_WORDS];
  logic [DATA_WIDTH-1:0] saved_dmem [MEM_WORDS];

  // Observed and expected access traces
  logic [ADDR_WIDTH-1:0] fetch_seen [$];
  logic [ADDR_WIDTH-1:0] fetch_ref [$];
  logic [ADDR_WIDTH-1:0] data_addr_seen [$];
  logic [ADDR_WIDTH-1:0] data_addr_ref [$];
  logic                  data_we_seen [$];
  logic                  data_we_ref [$];

  // Ack delay state
  integer                seed = 40019;
  bit                    delay_random;
  int                    imem_wait;
  int                    dmem_wait;
  bit                    imem_pending;
  bit                    dmem_pending;
  logic [ADDR_WIDTH-1:0] imem_hold;
  logic [ADDR_WIDTH-1:0] dmem_hold;

  int                    load_ptr;
  int                    cycles;
  int                    checks;
  int                    errors;

  simple_processor dut (
    .clk_i        (clk),
    .arst_ni      (arst_n),
    .boot_addr_i  (boot_addr),
    .imem_req_o   (imem_req),
    .imem_addr_o  (imem_addr),
    .imem_rdata_i (imem_rdata),
    .imem_ack_i   (imem_ack),
    .dmem_req_o   (dmem_req),
    .dmem_we_o    (dmem_we),
    .dmem_addr_o  (dmem_addr),
    .dmem_wdata_o (dmem_wdata),
    .dmem_rdata_i (dmem_rdata),
    .dmem_ack_i   (dmem_ack),
    .halted_o     (halted)
  );

  ////////////////////
  // Clock and watchdog
  ////////////////////

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("Timeout: the core did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("=== FAIL ===");
      $finish;
    end
  end

  ////////////////////
  // Helpers
  ////////////////////

  task automatic expect_eq(input logic [DATA_WIDTH-1:0] got,
                           input logic [DATA_WIDTH-1:0] exp, input string what);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERR %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  function automatic int draw_delay();
    return delay_random ? int'($unsigned($random(seed)) % 4) : 0;
  endfunction

  // Pattern depends on every address bit
  function automatic logic [DATA_WIDTH-1:0] fill_word(input int a);
    return 16'(a * 40503) ^ 16'hA5C3;
  endfunction

  function automatic logic [DATA_WIDTH-1:0] encode_reg(input opcode_e op, input int rd,
                                                       input int rs1, input int rs2);
    return {op, 3'(rd), 3'(rs1), 3'(rs2), 3'b000};
  endfunction

  function automatic logic [DATA_WIDTH-1:0] encode_imm(input opcode_e op, input int rd,
                                                       input int rs1, input int imm);
    return {op, 3'(rd), 3'(rs1), 6'(imm)};
  endfunction

  // Unused words hold HALT so a runaway PC stops
  task automatic start_program(input logic [ADDR_WIDTH-1:0] boot);
    for (int a = 0; a < MEM_WORDS; a++) begin
      imem[a] = {OP_HALT, 12'(a)};
    end
    load_ptr = int'(boot[8:1]);
  endtask

  task automatic emit(input logic [DATA_WIDTH-1:0] word);
    imem[load_ptr] = word;
    load_ptr++;
  endtask

  ////////////////////
  // Memory models, one falling edge per call
  ////////////////////

  task automatic step();
    @(negedge clk);
    imem_ack = 1'b0;
    dmem_ack = 1'b0;
    if (!arst_n) begin
      imem_pending = 1'b0;
      dmem_pending = 1'b0;
    end else begin
      if (imem_req) begin
        if (imem_pending) begin
          expect_eq(imem_addr, imem_hold, "fetch address while waiting");
        end
        imem_hold    = imem_addr;
        imem_pending = 1'b1;
        if (imem_wait == 0) begin
          imem_ack     = 1'b1;
          imem_rdata   = imem[imem_addr[8:1]];
          imem_pending = 1'b0;
          imem_wait    = draw_delay();
          fetch_seen.push_back(imem_addr);
        end else begin
          imem_wait--;
        end
      end
      if (dmem_req) begin
        if (dmem_pending) begin
          expect_eq(dmem_addr, dmem_hold, "data address while waiting");
        end
        dmem_hold    = dmem_addr;
        dmem_pending = 1'b1;
        if (dmem_wait == 0) begin
          dmem_ack     = 1'b1;
          dmem_pending = 1'b0;
          dmem_wait    = draw_delay();
          // Word addressed, low bits select the model entry
          if (dmem_we) begin
            dmem[dmem_addr[7:0]] = dmem_wdata;
          end else begin
            dmem_rdata = dmem[dmem_addr[7:0]];
          end
          data_addr_seen.push_back(dmem_addr);
          data_we_seen.push_back(dmem_we);
        end else begin
          dmem_wait--;
        end
      end
    end
  endtask

  ////////////////////
  // Reference model
  ////////////////////

  task automatic run_model(input logic [ADDR_WIDTH-1:0] boot);
    logic [DATA_WIDTH-1:0] regs [NUM_REGS];
    logic [DATA_WIDTH-1:0] ins;
    logic [DATA_WIDTH-1:0] imm;
    logic [DATA_WIDTH-1:0] addr;
    logic [ADDR_WIDTH-1:0] pc;
    logic [2:0]            rd;
    logic [2:0]            rs1;
    logic [2:0]            rs2;
    bit                    done;
    int                    steps;
    for (int r = 0; r < NUM_REGS; r++) begin
      regs[r] = '0;
    end
    pc    = boot;
    done  = 1'b0;
    steps = 0;
    while (!done && steps < 64) begin
      ins  = imem[pc[8:1]];
      fetch_ref.push_back(pc);
      rd   = ins[11:9];
      rs1  = ins[8:6];
      rs2  = ins[5:3];
      imm  = {{(DATA_WIDTH-IMM_WIDTH){ins[5]}}, ins[5:0]};
      addr = regs[rs1] + imm;
      pc   = pc + 16'd2;
      case (ins[15:12])
        OP_ADD:  regs[rd] = regs[rs1] + regs[rs2];
        OP_SUB:  regs[rd] = regs[rs1] - regs[rs2];
        OP_AND:  regs[rd] = regs[rs1] & regs[rs2];
        OP_OR:   regs[rd] = regs[rs1] | regs[rs2];
        OP_XOR:  regs[rd] = regs[rs1] ^ regs[rs2];
        OP_ADDI: regs[rd] = addr;
        OP_LOAD: begin
          regs[rd] = ref_dmem[addr[7:0]];
          data_addr_ref.push_back(addr);
          data_we_ref.push_back(1'b0);
        end
        OP_STORE: begin
          ref_dmem[addr[7:0]] = regs[rd];
          data_addr_ref.push_back(addr);
          data_we_ref.push_back(1'b1);
        end
        // Offset counts instructions
        OP_BEQZ: begin
          if (regs[rd] == '0) begin
            pc = pc + {imm[14:0], 1'b0};
          end
        end
        OP_HALT: done = 1'b1;
        default: ;
      endcase
      regs[0] = '0;
      steps++;
    end
  endtask

  ////////////////////
  // Run control
  ////////////////////

  task automatic reset_core(input logic [ADDR_WIDTH-1:0] boot);
    arst_n    = 1'b0;
    boot_addr = boot;
    repeat (2) begin
      step();
      checks++;
      assert (!imem_req && !dmem_req && !halted) else begin
        errors++;
        $display("ERR %0t ns: request or halt active during reset", $time);
      end
    end
    arst_n = 1'b1;
  endtask

  task automatic run_program(input logic [ADDR_WIDTH-1:0] boot, input bit random_acks);
    delay_random = random_acks;
    for (int a = 0; a < MEM_WORDS; a++) begin
      dmem[a]     = fill_word(a);
      ref_dmem[a] = dmem[a];
    end
    fetch_seen.delete();
    fetch_ref.delete();
    data_addr_seen.delete();
    data_addr_ref.delete();
    data_we_seen.delete();
    data_we_ref.delete();
    imem_wait = draw_delay();
    dmem_wait = draw_delay();
    run_model(boot);
    reset_core(boot);
    while (!halted) begin
      step();
    end
    expect_eq(16'(fetch_seen.size()), 16'(fetch_ref.size()), "fetch count");
    foreach (fetch_ref[i]) begin
      if (i < fetch_seen.size()) begin
        expect_eq(fetch_seen[i], fetch_ref[i], $sformatf("fetch %0d address", i));
      end
    end
    expect_eq(16'(data_addr_seen.size()), 16'(data_addr_ref.size()), "data access count");
    foreach (data_addr_ref[i]) begin
      if (i < data_addr_seen.size()) begin
        expect_eq(data_addr_seen[i], data_addr_ref[i], $sformatf("data %0d address", i));
        expect_eq(16'(data_we_seen[i]), 16'(data_we_ref[i]), $sformatf("data %0d we", i));
      end
    end
    for (int a = 0; a < MEM_WORDS; a++) begin
      expect_eq(dmem[a], ref_dmem[a], $sformatf("dmem[%0d]", a));
    end
    // Halt must be final
    repeat (20) begin
      step();
      checks++;
      assert (!imem_req && !dmem_req && halted) else begin
        errors++;
        $display("ERR %0t ns: request raised or halt dropped after halt", $time);
      end
    end
  endtask

  ////////////////////
  // Directed tests
  ////////////////////

  task automatic test_reset_boot();
    start_program(16'h0040);
    emit(encode_imm(OP_ADDI, 1, 0, 5));
    emit(encode_imm(OP_ADDI, 2, 1, -2));
    emit(encode_imm(OP_STORE, 2, 0, 10));
    emit(encode_reg(OP_HALT, 0, 0, 0));
    run_program(16'h0040, 1'b1);
    if (fetch_seen.size() > 0) begin
      expect_eq(fetch_seen[0], 16'h0040, "first fetch address");
    end
    // Straight-line code, one instruction every 2 bytes from boot
    for (int i = 1; i < fetch_seen.size(); i++) begin
      expect_eq(fetch_seen[i], 16'h0040 + 16'(2 * i), "straight-line fetch step");
    end
  endtask

  task automatic test_alu_ops();
    start_program(16'h0080);
    emit(encode_imm(OP_ADDI, 1, 0, 7));
    emit(encode_imm(OP_ADDI, 2, 0, 12));
    emit(encode_reg(OP_ADD, 3, 1, 2));
    emit(encode_imm(OP_STORE, 3, 0, 16));
    // 7 - 12 wraps below zero
    emit(encode_reg(OP_SUB, 4, 1, 2));
    emit(encode_imm(OP_STORE, 4, 0, 17));
    emit(encode_reg(OP_AND, 5, 1, 2));
    emit(encode_imm(OP_STORE, 5, 0, 18));
    emit(encode_reg(OP_OR, 6, 1, 2));
    emit(encode_imm(OP_STORE, 6, 0, 19));
    emit(encode_reg(OP_XOR, 7, 1, 2));
    emit(encode_imm(OP_STORE, 7, 0, 20));
    emit(encode_reg(OP_ADD, 0, 1, 2));
    emit(encode_imm(OP_STORE, 0, 0, 21));
    emit(encode_reg(OP_HALT, 0, 0, 0));
    run_program(16'h0080, 1'b1);
    expect_eq(dmem[21], 16'h0000, "stored r0");
  endtask

  task automatic build_load_store();
    start_program(16'h0100);
    emit(encode_imm(OP_ADDI, 1, 0, 20));
    emit(encode_imm(OP_LOAD, 2, 1, -3));
    emit(encode_imm(OP_LOAD, 3, 1, 5));
    emit(encode_reg(OP_ADD, 4, 2, 3));
    emit(encode_reg(OP_XOR, 5, 2, 3));
    emit(encode_imm(OP_STORE, 4, 1, -3));
    emit(encode_imm(OP_STORE, 5, 1, 5));
    emit(encode_imm(OP_LOAD, 6, 1, -3));
    emit(encode_imm(OP_ADDI, 6, 6, 1));
    emit(encode_imm(OP_STORE, 6, 1, 6));
    emit(encode_reg(OP_HALT, 0, 0, 0));
  endtask

  task automatic test_load_store();
    build_load_store();
    run_program(16'h0100, 1'b1);
  endtask

  task automatic test_branch();
    start_program(16'h0020);
    // Counted loop, three passes adding 5
    emit(encode_imm(OP_ADDI, 1, 0, 3));
    emit(encode_imm(OP_ADDI, 2, 2, 5));
    emit(encode_imm(OP_ADDI, 1, 1, -1));
    emit(encode_imm(OP_BEQZ, 1, 0, 1));
    emit(encode_imm(OP_BEQZ, 0, 0, -4));
    emit(encode_imm(OP_STORE, 2, 0, 30));
    // Not taken, marker follows
    emit(encode_imm(OP_BEQZ, 2, 0, 1));
    emit(encode_imm(OP_ADDI, 3, 0, 9));
    emit(encode_imm(OP_STORE, 3, 0, 31));
    // Taken forward over the store to 32
    emit(encode_imm(OP_BEQZ, 0, 0, 1));
    emit(encode_imm(OP_STORE, 3, 0, 32));
    emit(encode_reg(OP_HALT, 0, 0, 0));
    run_program(16'h0020, 1'b1);
    expect_eq(dmem[32], fill_word(32), "skipped marker");
  endtask

  task automatic test_halt_backpressure();
    build_load_store();
    run_program(16'h0100, 1'b0);
    for (int a = 0; a < MEM_WORDS; a++) begin
      saved_dmem[a] = dmem[a];
    end
    run_program(16'h0100, 1'b1);
    for (int a = 0; a < MEM_WORDS; a++) begin
      expect_eq(dmem[a], saved_dmem[a], $sformatf("dmem[%0d] across ack timing", a));
    end
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    arst_n     = 1'b0;
    boot_addr  = '0;
    imem_rdata = '0;
    imem_ack   = 1'b0;
    dmem_rdata = '0;
    dmem_ack   = 1'b0;
    test_reset_boot();
    test_alu_ops();
    test_load_store();
    test_branch();
    test_halt_backpressure();
    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* compile.f */
verilog/simple_processor_pkg.sv
verilog/simple_processor_isa_pkg.sv
verilog/ins_dec.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/simple_processor.sv
bench/tb_simple_processor.sv

/* run.sh */
#!/bin/sh
# Build and run the simple processor testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f compile.f --top-module tb_simple_processor -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
echo "Simulation finished without failure"
